/* verilog/rf_geom_pkg.sv */
/*
 * Geometry of the 16x27 power-gated register file and the word types shared
 * by the wrapper, the storage model and the testbench
 */
package rf_geom_pkg;

    // --------------------
    // Array size
    // --------------------

    // Number of entries in the array
    localparam int RF_DEPTH = 16;

    // Address width follows the depth
    localparam int RF_AW = $clog2(RF_DEPTH);

    // Logical word as seen at the wrapper ports
    localparam int RF_DW = 27;

    // Physical column count, the top column is a spare that is always written as zero
    localparam int RF_PW = 28;

    // --------------------
    // Word types
    // --------------------

    typedef logic [RF_AW-1:0] rf_addr_t;

    typedef logic [RF_DW-1:0] rf_data_t;

    typedef logic [RF_PW-1:0] rf_phys_t;

endpackage

/* verilog/rf_pwr_pkg.sv */
/*
 * Power management constants for the register file: the length of the
 * power-switch delay chain, the reset synchronizer depth and the power state
 */
package rf_pwr_pkg;

    // --------------------
    // Delay lengths
    // --------------------

    // Stages between the power enable request and the array
    // (each stage stands for one group of power switches)
    localparam int PWR_CHAIN_LEN = 4;

    // Flops in the read-side reset synchronizer
    localparam int RST_SYNC_LEN = 2;

    // --------------------
    // Power state
    // --------------------

    // The two transient states are reported while the chain stages disagree
    typedef enum logic [1:0] {
        pwr_off      = 2'b00,
        pwr_waking   = 2'b01,
        pwr_on       = 2'b10,
        pwr_sleeping = 2'b11
    } pwr_state_t;

endpackage

/* verilog/mem_reset_sync.sv */
/*
 * Brings the array reset into the read clock domain, with a scan bypass
 * that hands the reset straight to the tester in test mode
 */
module mem_reset_sync
    import rf_pwr_pkg::*;
(
     input  logic clk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Ones shift in from the bottom once reset has been seen high
    logic [RST_SYNC_LEN-1:0] sync_q;

    // --------------------
    // Synchronizer
    // --------------------

    // Every stage clears on a low reset, so release takes RST_SYNC_LEN edges
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_LEN-2:0], 1'b1};
        end
    end

    // In scan mode the tester drives the reset directly with no flop delay
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[RST_SYNC_LEN-1];
        end
    end

    // Outside bypass a low reset must hold the synchronized reset low on the next edge
    ap_no_early_release: assert property (@(posedge clk)
        (!rst_n && !fscan_rstbypen) |=> (fscan_rstbypen || !rst_n_sync));

endmodule

/* verilog/rf_pwr_chain.sv */
/*
 * Staged power switch model for the array. The active-low enable ripples
 * through a shift chain to the array and back out to the next macro
 */
module rf_pwr_chain
    import rf_pwr_pkg::*;
(
     input  logic       rclk
    ,input  logic       rst_n_sync
    ,input  logic       pwr_enable_b_in
    ,output logic       pwr_enable_b_out
    ,output pwr_state_t pwr_state
);

    // Stage 0 takes the request, the last stage feeds the output port
    logic [PWR_CHAIN_LEN-1:0] stage_q;

    // --------------------
    // Switch chain
    // --------------------

    // All switches open on reset, which means the array starts powered down
    always_ff @(posedge rclk) begin
        if (!rst_n_sync) begin
            stage_q <= '1;
        end else begin
            stage_q <= {stage_q[PWR_CHAIN_LEN-2:0], pwr_enable_b_in};
        end
    end

    // The enable leaves the macro only after passing every switch group
    assign pwr_enable_b_out = stage_q[PWR_CHAIN_LEN-1];

    // --------------------
    // State decode
    // --------------------

    // Fully closed chain means the array has power
    // An open chain means it is off, anything between is a transition
    always_comb begin
        if (~|stage_q) begin
            pwr_state = pwr_on;
        end else if (&stage_q) begin
            pwr_state = pwr_off;
        end else if (stage_q[0]) begin
            // Newest stage asks for power off, so the chain is going down
            pwr_state = pwr_sleeping;
        end else begin
            pwr_state = pwr_waking;
        end
    end

    // The output may only flip to a value that the previous stage already held
    // which keeps the switch groups turning on and off in order
    ap_ordered_switch: assert property (@(posedge rclk)
        ($past(rst_n_sync) && $changed(pwr_enable_b_out))
        |-> (pwr_enable_b_out == $past(stage_q[PWR_CHAIN_LEN-2])));

endmodule

/* verilog/rf_array_2p.sv */
/*
 * Behavioral two-port storage array with per-entry valid bits. Writes on
 * wclk, registered reads on rclk, contents are lost whenever power drops
 */
module rf_array_2p
    import rf_geom_pkg::*, rf_pwr_pkg::*;
#(
     parameter type payload_t = rf_phys_t
)(
     input  logic       wclk
    ,input  logic       we
    ,input  rf_addr_t   waddr
    ,input  payload_t   wdata
    ,input  logic       rclk
    ,input  logic       rst_n_sync
    ,input  logic       re
    ,input  rf_addr_t   raddr
    ,input  pwr_state_t pwr_state
    ,output payload_t   rdata
);

    // Storage cells, no reset as in the real bitcell array
    payload_t mem_q [RF_DEPTH];

    // An entry is valid while its set and clear flags differ
    // Set flags live on the write clock, clear flags on the read clock
    logic [RF_DEPTH-1:0] set_q;
    logic [RF_DEPTH-1:0] clr_q;
    logic [RF_DEPTH-1:0] entry_valid;

    logic     wr_en;
    logic     array_on;
    payload_t rdata_q;

    // The power state is quasi-static, so both ports sample it directly
    assign array_on    = (pwr_state == pwr_on);
    assign wr_en       = we && array_on;
    assign entry_valid = set_q ^ clr_q;

    // --------------------
    // Write port
    // --------------------

    // Data columns only change on an accepted write
    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem_q[waddr] <= wdata;
        end
    end

    // A write marks its entry valid by making the set flag differ from the clear flag
    always_ff @(posedge wclk) begin
        if (!rst_n_sync) begin
            set_q <= '0;
        end else if (wr_en) begin
            set_q[waddr] <= ~clr_q[waddr];
        end
    end

    // --------------------
    // Power loss
    // --------------------

    // Copying the set flags makes every entry invalid on the first edge without power
    // No writes land while the array is off, so the copy stays stable
    always_ff @(posedge rclk) begin
        if (!rst_n_sync) begin
            clr_q <= '0;
        end else if (!array_on) begin
            clr_q <= set_q;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Invalid entries and an unpowered array both read back as zero
    always_ff @(posedge rclk) begin
        if (!rst_n_sync) begin
            rdata_q <= '0;
        end else if (re) begin
            if (entry_valid[raddr] && array_on) begin
                rdata_q <= mem_q[raddr];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // The read register holds its value until the next read strobe
    assign rdata = rdata_q;

    // Unknown addresses would corrupt or read an undefined entry
    ap_waddr_known: assert property (@(posedge wclk)
        we |-> !$isunknown(waddr));

    ap_raddr_known: assert property (@(posedge rclk)
        re |-> !$isunknown(raddr));

endmodule

/* verilog/rf_pg_16x27.sv */
/*
 * Power-gated 16x27 two-port register file. Pads the logical word onto the
 * 28-bit physical array and clamps the read data while isolation is on
 */
module rf_pg_16x27
    import rf_geom_pkg::*, rf_pwr_pkg::*;
(
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    ,input  logic     rclk
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_data_t rdata

    ,input  logic     rst_n

    // Power management handshake with the gating controller
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in
    ,output logic     pwr_enable_b_out

    // Scan control of the array reset
    ,input  logic     fscan_rstbypen
    ,input  logic     fscan_byprst_b
);

    logic       rst_n_sync;
    pwr_state_t pwr_state;
    rf_phys_t   wdata_phys;
    rf_phys_t   rdata_phys;
    rf_phys_t   rdata_clamp;

    // --------------------
    // Reset and power
    // --------------------

    // Array reset runs in the read clock domain
    mem_reset_sync i_rst_sync (
         .clk            (rclk)
        ,.rst_n          (rst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rst_n_sync)
    );

    rf_pwr_chain i_pwr_chain (
         .rclk             (rclk)
        ,.rst_n_sync       (rst_n_sync)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_state        (pwr_state)
    );

    // --------------------
    // Storage
    // --------------------

    // Spare column is tied low on every write
    assign wdata_phys = {{(RF_PW-RF_DW){1'b0}}, wdata};

    rf_array_2p #(
         .payload_t (rf_phys_t)
    ) i_rf (
         .wclk       (wclk)
        ,.we         (we)
        ,.waddr      (waddr)
        ,.wdata      (wdata_phys)
        ,.rclk       (rclk)
        ,.rst_n_sync (rst_n_sync)
        ,.re         (re)
        ,.raddr      (raddr)
        ,.pwr_state  (pwr_state)
        ,.rdata      (rdata_phys)
    );

    // Isolation forces the outputs low so a powered-down array cannot drive
    // floating values into the logic that reads it
    assign rdata_clamp = pgcb_isol_en ? '0 : rdata_phys;

    // Drop the spare column on the way out
    assign rdata = rdata_clamp[RF_DW-1:0];

endmodule

/* verification/tb_rf_pg_16x27.sv */
/*
 * Directed testbench for the power-gated 16x27 register file. Each test is a
 * task that drives the wrapper and checks rdata and pwr_enable_b_out
 */
module tb_rf_pg_16x27
    import rf_geom_pkg::*, rf_pwr_pkg::*;
();

    // All six tests together take under 200 read cycles, so this is a wide margin
    localparam int CYCLE_LIMIT = 2000;

    // Read clock starts high, so its first rising edge comes at 30
    logic     wclk = 1'b0;
    logic     rclk = 1'b1;
    logic     we;
    logic     re;
    logic     rst_n;
    logic     pgcb_isol_en;
    logic     pwr_enable_b_in;
    logic     pwr_enable_b_out;
    logic     fscan_rstbypen;
    logic     fscan_byprst_b;
    rf_addr_t waddr;
    rf_addr_t raddr;
    rf_data_t wdata;
    rf_data_t rdata;

    // Reference model of the array contents and of the power level
    rf_data_t model_mem [RF_DEPTH];
    logic     model_valid [RF_DEPTH];
    logic     model_powered;

    // Read order for a burst, filled by the test before the burst starts
    rf_addr_t rd_order [RF_DEPTH];
    int       rd_count;

    logic [31:0] lfsr_state;
    string       cur_test;
    int          cycle_count;
    int          tests_run;
    int          tests_failed;
    int          checks;
    int          errors;
    int          test_errors;

    rf_pg_16x27 i_dut (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.rst_n            (rst_n)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

    // --------------------
    // Clocks and watchdog
    // --------------------

    always #20 wclk = ~wclk;

    // Read clock rises 10 units after each write clock edge
    always begin
        #10;
        rclk = ~rclk;
        #10;
    end

    always @(posedge rclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d read clock cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------

    // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Invalid entries and an unpowered array read as zero
    function automatic rf_data_t model_read(input rf_addr_t a);
        if (model_powered && model_valid[a]) begin
            return model_mem[a];
        end
        return '0;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < RF_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    // Inputs change 2 units after the edge, outputs are sampled there too
    task automatic wait_rclk();
        @(posedge rclk);
        #2;
    endtask

    task automatic wait_wclk();
        @(posedge wclk);
        #2;
    endtask

    task automatic check_data(input rf_data_t exp, input rf_data_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", cur_test, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pwr(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", cur_test, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    // A write lands only when the model says the array has power
    task automatic write_word(input rf_addr_t a, input rf_data_t d);
        wait_wclk();
        we = 1'b1;
        waddr = a;
        wdata = d;
        wait_wclk();
        we = 1'b0;
        if (model_powered) begin
            model_mem[a] = d;
            model_valid[a] = 1'b1;
        end
    endtask

    // Back-to-back reads, each result checked one edge after its strobe
    task automatic read_burst();
        wait_rclk();
        for (int i = 0; i < rd_count; i++) begin
            re = 1'b1;
            raddr = rd_order[i];
            wait_rclk();
            check_data(model_read(rd_order[i]), rdata);
        end
        re = 1'b0;
    endtask

    task automatic order_linear();
        for (int i = 0; i < RF_DEPTH; i++) begin
            rd_order[i] = rf_addr_t'(i);
        end
        rd_count = RF_DEPTH;
    endtask

    task automatic order_shuffled();
        int j;
        rf_addr_t tmp;
        order_linear();
        for (int i = RF_DEPTH - 1; i > 0; i--) begin
            j = rand_bits(8) % (i + 1);
            tmp = rd_order[i];
            rd_order[i] = rd_order[j];
            rd_order[j] = tmp;
        end
    endtask

    // The enable output holds its old value until the last stage is reached
    task automatic expect_pwr_ramp(input logic final_val);
        for (int i = 1; i <= PWR_CHAIN_LEN; i++) begin
            wait_rclk();
            check_pwr((i < PWR_CHAIN_LEN) ? ~final_val : final_val, pwr_enable_b_out);
        end
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic test_reset_state();
        start_test("reset_state");
        check_pwr(1'b1, pwr_enable_b_out);
        check_data('0, rdata);
        rd_order[0] = 4'd3;
        rd_count = 1;
        read_burst();
        end_test();
    endtask

    task automatic test_power_up();
        start_test("power_up");
        pwr_enable_b_in = 1'b0;
        expect_pwr_ramp(1'b0);
        model_powered = 1'b1;
        end_test();
    endtask

    task automatic test_write_read();
        start_test("write_read");
        for (int i = 0; i < RF_DEPTH; i++) begin
            write_word(rf_addr_t'(i), rf_data_t'(rand_bits(RF_DW)));
        end
        order_shuffled();
        read_burst();
        end_test();
    endtask

    task automatic test_power_loss();
        start_test("power_loss");
        wait_rclk();
        pwr_enable_b_in = 1'b1;
        expect_pwr_ramp(1'b1);
        model_powered = 1'b0;
        clear_model();
        // These must be dropped by the unpowered array
        for (int i = 0; i < 4; i++) begin
            write_word(rf_addr_t'(i), rf_data_t'(rand_bits(RF_DW)));
        end
        wait_rclk();
        pwr_enable_b_in = 1'b0;
        expect_pwr_ramp(1'b0);
        model_powered = 1'b1;
        order_linear();
        read_burst();
        end_test();
    endtask

    task automatic test_isolation();
        start_test("isolation");
        write_word(4'd5, rf_data_t'(rand_bits(RF_DW)));
        write_word(4'd9, rf_data_t'(rand_bits(RF_DW)));
        rd_order[0] = 4'd5;
        rd_count = 1;
        read_burst();
        pgcb_isol_en = 1'b1;
        #1;
        check_data('0, rdata);
        // The read register keeps loading behind the clamp
        wait_rclk();
        re = 1'b1;
        raddr = 4'd9;
        wait_rclk();
        re = 1'b0;
        check_data('0, rdata);
        wait_rclk();
        pgcb_isol_en = 1'b0;
        #1;
        check_data(model_read(4'd9), rdata);
        end_test();
    endtask

    task automatic test_scan_bypass();
        start_test("scan_bypass");
        wait_rclk();
        fscan_byprst_b = 1'b0;
        fscan_rstbypen = 1'b1;
        wait_rclk();
        check_pwr(1'b1, pwr_enable_b_out);
        check_data('0, rdata);
        // Hold long enough for the write side to see the reset as well
        repeat (3) wait_rclk();
        check_pwr(1'b1, pwr_enable_b_out);
        clear_model();
        fscan_byprst_b = 1'b1;
        fscan_rstbypen = 1'b0;
        expect_pwr_ramp(1'b0);
        rd_order[0] = 4'd5;
        rd_count = 1;
        read_burst();
        end_test();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        we = 1'b0;
        re = 1'b0;
        waddr = '0;
        raddr = '0;
        wdata = '0;
        rst_n = 1'b0;
        pgcb_isol_en = 1'b0;
        pwr_enable_b_in = 1'b1;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        lfsr_state = 32'h7f6f6733;
        model_powered = 1'b0;
        clear_model();
        cycle_count = 0;
        tests_run = 0;
        tests_failed = 0;
        checks = 0;
        errors = 0;

        repeat (8) @(posedge rclk);
        #2;
        rst_n = 1'b1;
        // Let the synchronized reset release before the first test
        repeat (RST_SYNC_LEN + 2) wait_rclk();

        test_reset_state();
        test_power_up();
        test_write_read();
        test_power_loss();
        test_isolation();
        test_scan_bypass();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/rf_geom_pkg.sv
verilog/rf_pwr_pkg.sv
verilog/mem_reset_sync.sv
verilog/rf_pwr_chain.sv
verilog/rf_array_2p.sv
verilog/rf_pg_16x27.sv
verification/tb_rf_pg_16x27.sv
